// File: Makefile
TOP = irq_ctrl_tb

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --timescale 1ns/100ps -j 0 --top-module $(TOP) -f files.f

run: build
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "RESULT: PASS"

lint:
	verilator --lint-only -Wall --timing --timescale 1ns/100ps --top-module $(TOP) -f files.f

clean:
	rm -rf obj_dir

// File: files.f
verilog/irq_pkg.sv
verilog/irq_enable_reg.sv
verilog/irq_flag_reg.sv
verilog/irq_priority.sv
verilog/irq_dispatch.sv
verilog/irq_ctrl_top.sv
test/tb_clock.sv
test/irq_ctrl_tb.sv

// File: test/irq_ctrl_tb.sv
// Interrupt controller testbench
module irq_ctrl_tb;
	timeunit 1ns;
	timeprecision 100ps;

	localparam irq_pkg::vector_t VEC_BASE = 16'h0040;

	logic clk;
	logic rst;
	irq_pkg::bus_req_t bus_req;
	irq_pkg::bus_data_t rdata;
	irq_pkg::irq_mask_t irq_trig;
	logic ime_set;
	logic ime_clr;
	logic vec_valid;
	logic vec_ready;
	irq_pkg::vector_t vec_addr;
	logic ime;
	logic wake;

	irq_pkg::irq_mask_t m_ie;	// Model IE
	irq_pkg::irq_mask_t m_if;	// Model IF
	irq_pkg::irq_mask_t m_prev;	// Previous trigger sample
	irq_pkg::irq_index_t m_idx;	// Source of the open offer
	logic m_ime;
	logic m_open;

	int errors = 0;
	int tests_run = 0;
	int tests_failed = 0;
	int errors_before = 0;

	tb_clock u_clock (.clk(clk), .rst(rst));

	irq_ctrl_top #(.VECTOR_BASE(VEC_BASE)) u_dut (.*);

	// Bit 0 has the highest priority
	function automatic irq_pkg::irq_index_t lowest_set(input irq_pkg::irq_mask_t m);
		irq_pkg::irq_index_t idx;
		idx = '0;
		for (int i = 7; i >= 0; i--) begin
			if (m[i]) idx = irq_pkg::irq_index_t'(i);
		end
		return idx;
	endfunction

	function automatic irq_pkg::vector_t vector_for(input irq_pkg::irq_index_t idx);
		return VEC_BASE + 16'(idx) * 16'd8;	// Table entries eight bytes apart
	endfunction

	task automatic report_mismatch(input string sig, input logic [15:0] got,
			input logic [15:0] exp);
		$display("ERROR %s: got 0x%0h, expected 0x%0h at %0t", sig, got, exp, $time);
		errors++;
	endtask

	task automatic note_failure(input string what);
		$display("Failure at %0t: %s", $time, what);
		errors++;
	endtask

	task automatic finish_test(input string name);
		tests_run++;
		if (errors != errors_before) tests_failed++;
		$display("Test %0d %s: %0d errors", tests_run, name, errors - errors_before);
		errors_before = errors;
	endtask

	task automatic write_reg(input irq_pkg::bus_addr_t reg_addr, input irq_pkg::bus_data_t data);
		@(posedge clk);
		bus_req <= '{addr: reg_addr, wdata: data, wr: 1'b1, rd: 1'b0};
		@(posedge clk);
		bus_req <= '0;
	endtask

	task automatic read_reg(input irq_pkg::bus_addr_t reg_addr, output irq_pkg::bus_data_t data);
		@(posedge clk);
		bus_req <= '{addr: reg_addr, wdata: 8'h00, wr: 1'b0, rd: 1'b1};
		@(posedge clk);
		bus_req <= '0;
		@(negedge clk);
		data = rdata;	// Valid on the cycle after the strobe
	endtask

	task automatic pulse_ime(input logic enable);
		@(posedge clk);
		ime_set <= enable;
		ime_clr <= !enable;
		@(posedge clk);
		ime_set <= 1'b0;
		ime_clr <= 1'b0;
	endtask

	task automatic take_vector();
		@(posedge clk);
		vec_ready <= 1'b1;
		@(posedge clk);
		vec_ready <= 1'b0;
	endtask

	// Watch vec_valid for up to limit cycles
	task automatic wait_valid(input int limit, output logic seen);
		int n;
		seen = 1'b0;
		n = 0;
		while (!seen && n < limit) begin
			@(negedge clk);
			seen = vec_valid;
			n++;
		end
	endtask

	always @(posedge clk) begin : model_step
		irq_pkg::irq_mask_t pend;
		irq_pkg::irq_mask_t ack_m;
		irq_pkg::irq_mask_t base;
		logic taken;
		pend = m_ie & m_if;
		taken = m_open & vec_ready;
		ack_m = '0;
		if (taken) ack_m[m_idx] = 1'b1;
		base = (bus_req.wr && bus_req.addr == irq_pkg::IF_ADDR) ? bus_req.wdata : m_if;
		m_prev <= irq_trig;	// Sampled through reset too
		if (rst) begin
			m_ie <= '0;
			m_if <= '0;
			m_ime <= 1'b0;
			m_open <= 1'b0;
		end else begin
			if (bus_req.wr && bus_req.addr == irq_pkg::IE_ADDR) m_ie <= bus_req.wdata;
			m_if <= (base & ~ack_m) | (irq_trig & ~m_prev);	// New edge wins
			if (ime_clr || taken) m_ime <= 1'b0;
			else if (ime_set) m_ime <= 1'b1;
			if (taken) begin
				m_open <= 1'b0;
			end else if (!m_open && m_ime && pend != '0) begin
				m_open <= 1'b1;
				m_idx <= lowest_set(pend);
			end
		end
	end

	always @(negedge clk) begin
		if (!rst) begin
			if (vec_valid !== m_open) report_mismatch("vec_valid", 16'(vec_valid), 16'(m_open));
			if (m_open && vec_addr !== vector_for(m_idx))
				report_mismatch("vec_addr", vec_addr, vector_for(m_idx));
			if (wake !== |(m_ie & m_if)) report_mismatch("wake", 16'(wake), 16'(|(m_ie & m_if)));
			if (ime !== m_ime) report_mismatch("ime", 16'(ime), 16'(m_ime));
		end
	end

	initial begin : stimulus
		irq_pkg::bus_data_t iev;
		irq_pkg::bus_data_t ifv;
		irq_pkg::bus_data_t got;
		irq_pkg::bus_data_t exp_if;
		irq_pkg::bus_addr_t addr;
		irq_pkg::irq_index_t idx;
		irq_pkg::vector_t held;
		logic seen;
		int n;
		bus_req <= '0;
		irq_trig <= '0;
		ime_set <= 1'b0;
		ime_clr <= 1'b0;
		vec_ready <= 1'b0;
		void'($urandom(5));
		n = 0;
		while (rst !== 1'b0 && n < 10) begin
			@(posedge clk);
			n++;
		end
		if (rst !== 1'b0) note_failure("reset was never released");

		@(negedge clk);
		if (vec_valid !== 1'b0) report_mismatch("vec_valid", 16'(vec_valid), 16'h0);
		if (wake !== 1'b0) report_mismatch("wake", 16'(wake), 16'h0);
		if (ime !== 1'b0) report_mismatch("ime", 16'(ime), 16'h0);
		read_reg(irq_pkg::IE_ADDR, got);
		if (got !== 8'h00) report_mismatch("rdata IE", 16'(got), 16'h0);
		read_reg(irq_pkg::IF_ADDR, got);
		if (got !== 8'h00) report_mismatch("rdata IF", 16'(got), 16'h0);
		finish_test("reset");

		for (int i = 0; i < 8; i++) begin
			iev = 8'($urandom);
			ifv = 8'($urandom);
			write_reg(irq_pkg::IE_ADDR, iev);
			write_reg(irq_pkg::IF_ADDR, ifv);
			read_reg(irq_pkg::IE_ADDR, got);
			if (got !== iev) report_mismatch("rdata IE", 16'(got), 16'(iev));
			read_reg(irq_pkg::IF_ADDR, got);
			if (got !== ifv) report_mismatch("rdata IF", 16'(got), 16'(ifv));
			addr = 16'($urandom);
			if (addr == irq_pkg::IE_ADDR || addr == irq_pkg::IF_ADDR) addr = 16'h0000;
			read_reg(addr, got);
			if (got !== 8'h00) report_mismatch("rdata unmapped", 16'(got), 16'h0);
		end
		finish_test("register access");

		write_reg(irq_pkg::IF_ADDR, 8'h00);
		exp_if = '0;
		iev = '0;	// Level now on the trigger lines
		for (int i = 0; i < 16; i++) begin
			ifv = 8'($urandom);
			exp_if = exp_if | (ifv & ~iev);
			iev = ifv;
			@(posedge clk);
			irq_trig <= ifv;
			read_reg(irq_pkg::IF_ADDR, got);
			if (got !== exp_if) report_mismatch("rdata IF", 16'(got), 16'(exp_if));
		end
		@(posedge clk);
		irq_trig <= 8'hFF;
		write_reg(irq_pkg::IF_ADDR, 8'h00);	// Lines stay high after the clear
		repeat (4) @(posedge clk);
		read_reg(irq_pkg::IF_ADDR, got);
		if (got !== 8'h00) report_mismatch("rdata IF held", 16'(got), 16'h0);
		@(posedge clk);
		irq_trig <= '0;
		finish_test("edge capture");

		for (int i = 0; i < 6; i++) begin
			iev = 8'($urandom);
			ifv = 8'($urandom);
			if ((iev & ifv) == 8'h00) begin
				iev[7] = 1'b1;
				ifv[7] = 1'b1;
			end
			idx = lowest_set(iev & ifv);
			write_reg(irq_pkg::IE_ADDR, iev);
			write_reg(irq_pkg::IF_ADDR, ifv);
			pulse_ime(1'b1);
			wait_valid(10, seen);
			if (!seen) note_failure("no vector offered for a pending source");
			if (vec_addr !== vector_for(idx))
				report_mismatch("vec_addr", vec_addr, vector_for(idx));
			take_vector();
			@(negedge clk);
			if (ime !== 1'b0) report_mismatch("ime", 16'(ime), 16'h0);
			read_reg(irq_pkg::IF_ADDR, got);
			exp_if = ifv & ~(8'h01 << idx);
			if (got !== exp_if) report_mismatch("rdata IF", 16'(got), 16'(exp_if));
		end
		finish_test("priority and vector");

		pulse_ime(1'b0);
		ifv = 8'($urandom) | 8'h01;
		write_reg(irq_pkg::IE_ADDR, 8'hFF);
		write_reg(irq_pkg::IF_ADDR, ifv);
		wait_valid(16, seen);
		if (seen) note_failure("vector offered while IME was clear");
		if (wake !== 1'b1) report_mismatch("wake", 16'(wake), 16'h1);
		write_reg(irq_pkg::IE_ADDR, ~ifv);	// Every flag masked
		pulse_ime(1'b1);
		wait_valid(16, seen);
		if (seen) note_failure("vector offered with every flag masked");
		if (wake !== 1'b0) report_mismatch("wake", 16'(wake), 16'h0);
		pulse_ime(1'b0);
		finish_test("gating");

		write_reg(irq_pkg::IE_ADDR, 8'hFF);
		for (int i = 0; i < 4; i++) begin
			ifv = (8'($urandom) | 8'h80) & 8'hFE;	// Bit 0 free for a late trigger
			idx = lowest_set(ifv);
			write_reg(irq_pkg::IF_ADDR, ifv);
			pulse_ime(1'b1);
			wait_valid(10, seen);
			if (!seen) note_failure("no vector offered before back-pressure");
			held = vec_addr;
			if (held !== vector_for(idx)) report_mismatch("vec_addr", held, vector_for(idx));
			n = 4 + int'($urandom % 13);
			for (int c = 0; c < n; c++) begin
				@(posedge clk);
				if (c == n / 2) irq_trig <= 8'h01;	// Higher priority arrives late
				@(negedge clk);
				if (vec_valid !== 1'b1) report_mismatch("vec_valid", 16'(vec_valid), 16'h1);
				if (vec_addr !== held) report_mismatch("vec_addr", vec_addr, held);
			end
			take_vector();
			read_reg(irq_pkg::IF_ADDR, got);
			exp_if = (ifv & ~(8'h01 << idx)) | 8'h01;
			if (got !== exp_if) report_mismatch("rdata IF", 16'(got), 16'(exp_if));
			@(posedge clk);
			irq_trig <= '0;
		end
		finish_test("back-pressure");

		$display("Tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
		if (errors == 0) begin
			$display("RESULT: PASS");
		end else begin
			$display("RESULT: FAIL");
		end
		$finish;
	end
endmodule

// File: test/tb_clock.sv
// Testbench clock and reset
module tb_clock (
	output logic clk,
	output logic rst
);
	timeunit 1ns;
	timeprecision 100ps;

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;	// 4 ns period
	end

	initial begin
		rst = 1'b1;
		repeat (3) @(posedge clk);	// Three rising edges in reset
		rst <= 1'b0;
	end
endmodule

// File: verilog/irq_ctrl_top.sv
// Interrupt controller top level
module irq_ctrl_top #(
	parameter irq_pkg::vector_t VECTOR_BASE = 16'h0040	// Vector table base
) (
	input logic clk,
	input logic rst,
	input irq_pkg::bus_req_t bus_req,
	output irq_pkg::bus_data_t rdata,
	input irq_pkg::irq_mask_t irq_trig,
	input logic ime_set,
	input logic ime_clr,
	output logic vec_valid,
	input logic vec_ready,
	output irq_pkg::vector_t vec_addr,
	output logic ime,
	output logic wake
);

	irq_pkg::irq_mask_t ie;	// Enable bits
	irq_pkg::irq_mask_t iflag;	// Request flags
	irq_pkg::irq_mask_t ack;	// Serviced source, one-hot
	irq_pkg::irq_pick_t pick;

	logic ie_rd_hit;
	logic if_rd_hit;
	irq_pkg::bus_data_t ie_rd_data;
	irq_pkg::bus_data_t if_rd_data;

	irq_enable_reg u_enable (
		.clk(clk),
		.rst(rst),
		.bus_req(bus_req),
		.ie(ie),
		.rd_hit(ie_rd_hit),
		.rd_data(ie_rd_data)
	);

	irq_flag_reg u_flag (
		.clk(clk),
		.rst(rst),
		.bus_req(bus_req),
		.irq_trig(irq_trig),
		.ack(ack),
		.iflag(iflag),
		.rd_hit(if_rd_hit),
		.rd_data(if_rd_data)
	);

	irq_priority u_priority (
		.ie(ie),
		.iflag(iflag),
		.pick(pick),
		.wake(wake)
	);

	irq_dispatch #(
		.VECTOR_BASE(VECTOR_BASE)
	) u_dispatch (
		.clk(clk),
		.rst(rst),
		.ime_set(ime_set),
		.ime_clr(ime_clr),
		.pick(pick),
		.vec_valid(vec_valid),
		.vec_ready(vec_ready),
		.vec_addr(vec_addr),
		.ack(ack),
		.ime(ime)
	);

	// Registers decode distinct addresses, unmapped reads give zero
	always_comb begin
		if (ie_rd_hit) begin
			rdata = ie_rd_data;
		end else if (if_rd_hit) begin
			rdata = if_rd_data;
		end else begin
			rdata = '0;
		end
	end

endmodule

// File: verilog/irq_dispatch.sv
// Interrupt vector dispatch
module irq_dispatch #(
	parameter irq_pkg::vector_t VECTOR_BASE = 16'h0040
) (
	input logic clk,
	input logic rst,
	input logic ime_set,
	input logic ime_clr,
	input irq_pkg::irq_pick_t pick,
	output logic vec_valid,
	input logic vec_ready,
	output irq_pkg::vector_t vec_addr,
	output irq_pkg::irq_mask_t ack,
	output logic ime
);

	typedef enum logic {
		IDLE,	// No vector offered
		OFFER	// Vector held until taken
	} state_t;

	state_t state;
	state_t state_next;

	irq_pkg::irq_index_t cap_index;	// Source frozen for this offer
	irq_pkg::vector_t vec_offset;

	logic start;	// Open a new offer
	logic handshake;	// Sequencer takes the vector

	assign start = (state == IDLE) & ime & pick.any;
	assign handshake = (state == OFFER) & vec_ready;

	always_comb begin
		state_next = state;
		case (state)
			IDLE: begin
				if (start) begin
					state_next = OFFER;
				end
			end
			OFFER: begin
				if (handshake) begin
					state_next = IDLE;	// Valid drops next cycle
				end
			end
			default: begin
				state_next = IDLE;
			end
		endcase
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= IDLE;
		end else begin
			state <= state_next;
		end
	end

	// Later, higher-priority flags do not move an open offer
	always_ff @(posedge clk) begin
		if (start) begin
			cap_index <= pick.index;
		end
	end

	// Master enable, a clear beats a set
	always_ff @(posedge clk) begin
		if (rst) begin
			ime <= 1'b0;
		end else if (ime_clr || handshake) begin
			ime <= 1'b0;	// Entry to a handler masks further offers
		end else if (ime_set) begin
			ime <= 1'b1;
		end
	end

	assign vec_valid = (state == OFFER);

	// Base plus eight times the source number
	assign vec_offset = irq_pkg::vector_t'(cap_index) << irq_pkg::VEC_SHIFT;
	assign vec_addr = VECTOR_BASE + vec_offset;

	// One-hot clear, only on the handshake cycle
	always_comb begin
		ack = '0;
		if (handshake) begin
			ack[cap_index] = 1'b1;
		end
	end

endmodule

// File: verilog/irq_enable_reg.sv
// Interrupt enable register
module irq_enable_reg (
	input logic clk,
	input logic rst,
	input irq_pkg::bus_req_t bus_req,
	output irq_pkg::irq_mask_t ie,
	output logic rd_hit,
	output irq_pkg::bus_data_t rd_data
);

	logic addr_hit;	// Address is 0xFFFF
	logic wr_en;
	logic rd_en;

	assign addr_hit = (bus_req.addr == irq_pkg::IE_ADDR);
	assign wr_en = bus_req.wr & addr_hit;
	assign rd_en = bus_req.rd & addr_hit;

	// IE load from the data bus
	always_ff @(posedge clk) begin
		if (rst) begin
			ie <= '0;	// All sources masked
		end else if (wr_en) begin
			ie <= irq_pkg::irq_mask_t'(bus_req.wdata);
		end
	end

	// Hit flag lasts one cycle
	always_ff @(posedge clk) begin
		if (rst) begin
			rd_hit <= 1'b0;
		end else begin
			rd_hit <= rd_en;
		end
	end

	// Read data follows the strobe by one cycle
	always_ff @(posedge clk) begin
		if (rd_en) begin
			rd_data <= irq_pkg::bus_data_t'(ie);	// Value before any same-cycle write
		end
	end

endmodule

// File: verilog/irq_flag_reg.sv
// Interrupt request flag register
module irq_flag_reg (
	input logic clk,
	input logic rst,
	input irq_pkg::bus_req_t bus_req,
	input irq_pkg::irq_mask_t irq_trig,
	input irq_pkg::irq_mask_t ack,
	output irq_pkg::irq_mask_t iflag,
	output logic rd_hit,
	output irq_pkg::bus_data_t rd_data
);

	irq_pkg::irq_mask_t trig_prev;	// Last trigger sample
	irq_pkg::irq_mask_t trig_rise;	// Low to high seen this cycle
	irq_pkg::irq_mask_t flag_base;	// After bus write and acknowledge
	irq_pkg::irq_mask_t flag_next;

	logic addr_hit;	// Address is 0xFF0F
	logic wr_en;
	logic rd_en;

	assign addr_hit = (bus_req.addr == irq_pkg::IF_ADDR);
	assign wr_en = bus_req.wr & addr_hit;
	assign rd_en = bus_req.rd & addr_hit;

	// Keeps sampling through reset, so a line already high
	// when reset ends is not taken as an edge
	always_ff @(posedge clk) begin
		trig_prev <= irq_trig;
	end

	assign trig_rise = irq_trig & ~trig_prev;

	// Bus write first, then acknowledge, and a new edge beats both
	always_comb begin
		if (wr_en) begin
			flag_base = irq_pkg::irq_mask_t'(bus_req.wdata);
		end else begin
			flag_base = iflag;
		end
		flag_base = flag_base & ~ack;	// Serviced source drops
		flag_next = flag_base | trig_rise;
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			iflag <= '0;	// No requests pending
		end else begin
			iflag <= flag_next;
		end
	end

	// Hit flag lasts one cycle
	always_ff @(posedge clk) begin
		if (rst) begin
			rd_hit <= 1'b0;
		end else begin
			rd_hit <= rd_en;
		end
	end

	// Read data follows the strobe by one cycle
	always_ff @(posedge clk) begin
		if (rd_en) begin
			rd_data <= irq_pkg::bus_data_t'(iflag);
		end
	end

endmodule

// File: verilog/irq_pkg.sv
// Interrupt controller shared types
package irq_pkg;

	// Source count is fixed by the 8-bit IE and IF registers
	localparam int IRQ_COUNT = 8;
	localparam int IDX_W = $clog2(IRQ_COUNT);	// Bits to name one source

	// One bit per interrupt source
	typedef logic [IRQ_COUNT-1:0] irq_mask_t;

	// Number of the winning source
	typedef logic [IDX_W-1:0] irq_index_t;

	typedef logic [15:0] bus_addr_t;	// CPU address bus
	typedef logic [7:0] bus_data_t;	// CPU data bus
	typedef logic [15:0] vector_t;	// Jump target handed to the sequencer

	localparam bus_addr_t IE_ADDR = 16'hFFFF;	// Interrupt enable
	localparam bus_addr_t IF_ADDR = 16'hFF0F;	// Interrupt request flags

	// Vector table entries are eight bytes apart
	localparam int VEC_SHIFT = 3;

	// Strobed register port, no stall
	typedef struct packed {
		bus_addr_t addr;	// Target register
		bus_data_t wdata;	// Write payload
		logic wr;	// Write strobe
		logic rd;	// Read strobe
	} bus_req_t;

	// Priority encoder result
	typedef struct packed {
		logic any;	// Some source enabled and pending
		irq_index_t index;	// Lowest such source
	} irq_pick_t;

endpackage

// File: verilog/irq_priority.sv
// Interrupt priority encoder
module irq_priority (
	input irq_pkg::irq_mask_t ie,
	input irq_pkg::irq_mask_t iflag,
	output irq_pkg::irq_pick_t pick,
	output logic wake
);

	irq_pkg::irq_mask_t pending;	// Enabled and requested
	irq_pkg::irq_mask_t blocked;	// Some lower source is pending
	irq_pkg::irq_mask_t grant;	// One-hot winner
	irq_pkg::irq_index_t grant_index;

	assign pending = ie & iflag;

	// Priority chain, bit 0 is highest
	assign blocked[0] = 1'b0;
	for (genvar i = 1; i < irq_pkg::IRQ_COUNT; i++) begin : g_chain
		assign blocked[i] = |pending[i-1:0];
	end

	assign grant = pending & ~blocked;

	// Encode the one-hot grant
	always_comb begin
		grant_index = '0;
		for (int i = 0; i < irq_pkg::IRQ_COUNT; i++) begin
			if (grant[i]) begin
				grant_index = grant_index | irq_pkg::irq_index_t'(i);
			end
		end
	end

	always_comb begin
		pick.any = |grant;	// Same as any pending bit
		pick.index = grant_index;
	end

	// Halt wake ignores IME
	assign wake = |pending;

endmodule
